// File: src/gbc_io_pkg.sv
package gbc_io_pkg;

   // ==================================================================
   // Widths and address map
   // ==================================================================
   localparam int DATA_W = 8;
   localparam int ADDR_W = 16;

   // Every register lives in the 0xFFxx page
   localparam logic [7:0] IO_PAGE   = 8'hFF;
   localparam logic [7:0] ADDR_DIV  = 8'h04;
   localparam logic [7:0] ADDR_TIMA = 8'h05;
   localparam logic [7:0] ADDR_TMA  = 8'h06;
   localparam logic [7:0] ADDR_TAC  = 8'h07;
   localparam logic [7:0] ADDR_IF   = 8'h0F;
   localparam logic [7:0] ADDR_IE   = 8'hFF;

   localparam int NUM_INT = 5;

   // DIV is the upper byte of the free-running counter
   localparam int DIV_STEP_BITS  = 8;
   localparam int HEARTBEAT_BITS = 21;

   localparam logic [DATA_W-1:0] UNMAPPED_READ = 8'hFF;

   // ==================================================================
   // Enumerations
   // ==================================================================
   typedef enum logic [2:0] {
      REG_DIV,
      REG_TIMA,
      REG_TMA,
      REG_TAC,
      REG_IF,
      REG_IE,
      REG_NONE
   } io_reg_e;

   // Bit positions in IF and IE
   // Lowest index has highest priority
   typedef enum logic [2:0] {
      INT_VBLANK  = 3'd0,
      INT_LCDSTAT = 3'd1,
      INT_TIMER   = 3'd2,
      INT_SERIAL  = 3'd3,
      INT_JOYPAD  = 3'd4
   } int_source_e;

   // TAC[1:0] values named by clocks per TIMA step
   typedef enum logic [1:0] {
      TAC_1024 = 2'd0,
      TAC_16   = 2'd1,
      TAC_64   = 2'd2,
      TAC_256  = 2'd3
   } tac_clock_e;

endpackage

// File: src/apb_io_port.sv
`timescale 1ns/10ps

module apb_io_port (
   input  logic                          clock_in,
   input  logic                          synch_reset,
   input  logic [gbc_io_pkg::ADDR_W-1:0] paddr,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [gbc_io_pkg::DATA_W-1:0] pwdata,
   input  logic [gbc_io_pkg::DATA_W-1:0] div_value,
   input  logic [gbc_io_pkg::DATA_W-1:0] tima_value,
   input  logic [gbc_io_pkg::DATA_W-1:0] tma_value,
   input  logic [gbc_io_pkg::DATA_W-1:0] tac_value,
   input  logic [gbc_io_pkg::DATA_W-1:0] if_value,
   input  logic [gbc_io_pkg::DATA_W-1:0] ie_value,
   output logic [gbc_io_pkg::DATA_W-1:0] prdata,
   output logic                          pready,
   output logic                          pslverr,
   output gbc_io_pkg::io_reg_e           reg_sel,
   output logic                          wr_en,
   output logic [gbc_io_pkg::DATA_W-1:0] wr_data
);
   import gbc_io_pkg::*;

   logic setup_q;
   logic access;
   logic mapped;

   // Remember a setup cycle so that the access phase is seen only once
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= psel & ~penable;
      end
   end

   assign access = psel & penable & setup_q;

   // Address decode with the page check first
   always_comb begin
      reg_sel = REG_NONE;
      if (paddr[ADDR_W-1:DATA_W] == IO_PAGE) begin
         case (paddr[DATA_W-1:0])
            ADDR_DIV:  reg_sel = REG_DIV;
            ADDR_TIMA: reg_sel = REG_TIMA;
            ADDR_TMA:  reg_sel = REG_TMA;
            ADDR_TAC:  reg_sel = REG_TAC;
            ADDR_IF:   reg_sel = REG_IF;
            ADDR_IE:   reg_sel = REG_IE;
            default:   reg_sel = REG_NONE;
         endcase
      end
   end

   assign mapped  = (reg_sel != REG_NONE);
   assign wr_en   = access & pwrite & mapped;
   assign wr_data = pwdata;
   assign pslverr = access & ~mapped;

   // No wait states
   assign pready = 1'b1;

   // Read mux showing register state before the closing edge
   always_comb begin
      case (reg_sel)
         REG_DIV:  prdata = div_value;
         REG_TIMA: prdata = tima_value;
         REG_TMA:  prdata = tma_value;
         REG_TAC:  prdata = tac_value;
         REG_IF:   prdata = if_value;
         REG_IE:   prdata = ie_value;
         default:  prdata = UNMAPPED_READ;
      endcase
   end

endmodule

// File: src/timer_unit.sv
`timescale 1ns/10ps

module timer_unit (
   input  logic                          clock_in,
   input  logic                          synch_reset,
   input  gbc_io_pkg::io_reg_e           reg_sel,
   input  logic                          wr_en,
   input  logic [gbc_io_pkg::DATA_W-1:0] wr_data,
   output logic [gbc_io_pkg::DATA_W-1:0] div_value,
   output logic [gbc_io_pkg::DATA_W-1:0] tima_value,
   output logic [gbc_io_pkg::DATA_W-1:0] tma_value,
   output logic [gbc_io_pkg::DATA_W-1:0] tac_value,
   output logic                          timer_req
);
   import gbc_io_pkg::*;

   logic [DIV_STEP_BITS+DATA_W-1:0] div_cnt;
   logic [DIV_STEP_BITS+DATA_W-1:0] step_mask;
   logic [DATA_W-1:0]               tima_q;
   logic [DATA_W-1:0]               tma_q;
   logic [2:0]                      tac_q;
   tac_clock_e                      tac_clk;
   logic                            step;
   logic                            div_wr;
   logic                            tima_wr;
   logic                            tma_wr;
   logic                            tac_wr;

   assign div_wr  = wr_en & (reg_sel == REG_DIV);
   assign tima_wr = wr_en & (reg_sel == REG_TIMA);
   assign tma_wr  = wr_en & (reg_sel == REG_TMA);
   assign tac_wr  = wr_en & (reg_sel == REG_TAC);

   assign tac_clk = tac_clock_e'(tac_q[1:0]);

   // ==================================================================
   // Step detect
   // ==================================================================
   // Low counter bits all ones means the next edge lands on a multiple
   // of the period
   always_comb begin
      step_mask = '0;
      case (tac_clk)
         TAC_1024: step_mask[9:0] = '1;
         TAC_16:   step_mask[3:0] = '1;
         TAC_64:   step_mask[5:0] = '1;
         TAC_256:  step_mask[7:0] = '1;
         default:  step_mask[9:0] = '1;
      endcase
   end

   // A DIV write clears the counter, so that edge is not a step
   assign step = tac_q[2] & ((div_cnt & step_mask) == step_mask) & ~div_wr;

   // ==================================================================
   // Registers
   // ==================================================================
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         div_cnt   <= '0;
         tima_q    <= '0;
         tma_q     <= '0;
         tac_q     <= '0;
         timer_req <= 1'b0;
      end else begin
         timer_req <= 1'b0;

         if (div_wr) begin
            div_cnt <= '0;
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end

         // Software write to TIMA beats a step in the same cycle
         if (tima_wr) begin
            tima_q <= wr_data;
         end else if (step) begin
            if (tima_q == '1) begin
               tima_q    <= tma_q;
               timer_req <= 1'b1;
            end else begin
               tima_q <= tima_q + 1'b1;
            end
         end

         if (tma_wr) begin
            tma_q <= wr_data;
         end
         if (tac_wr) begin
            tac_q <= wr_data[2:0];
         end
      end
   end

   assign div_value  = div_cnt[DIV_STEP_BITS+DATA_W-1:DIV_STEP_BITS];
   assign tima_value = tima_q;
   assign tma_value  = tma_q;
   // Unused TAC bits read high
   assign tac_value  = {{(DATA_W-3){1'b1}}, tac_q};

endmodule

// File: src/interrupt_unit.sv
`timescale 1ns/10ps

module interrupt_unit (
   input  logic                          clock_in,
   input  logic                          synch_reset,
   input  gbc_io_pkg::io_reg_e           reg_sel,
   input  logic                          wr_en,
   input  logic [gbc_io_pkg::DATA_W-1:0] wr_data,
   input  logic                          vblank_req,
   input  logic                          lcdstat_req,
   input  logic                          timer_req,
   input  logic                          joypad_req,
   output logic [gbc_io_pkg::DATA_W-1:0] if_value,
   output logic [gbc_io_pkg::DATA_W-1:0] ie_value,
   output logic                          irq,
   output gbc_io_pkg::int_source_e       irq_source
);
   import gbc_io_pkg::*;

   logic [NUM_INT-1:0] if_q;
   logic [NUM_INT-1:0] req_vec;
   logic [NUM_INT-1:0] pending;
   logic [DATA_W-1:0]  ie_q;
   logic               if_wr;
   logic               ie_wr;

   // Request pulses placed at their IF bit positions
   always_comb begin
      req_vec              = '0;
      req_vec[INT_VBLANK]  = vblank_req;
      req_vec[INT_LCDSTAT] = lcdstat_req;
      req_vec[INT_TIMER]   = timer_req;
      // Serial has no source here and its bit only moves by IF writes
      req_vec[INT_JOYPAD]  = joypad_req;
   end

   assign if_wr = wr_en & (reg_sel == REG_IF);
   assign ie_wr = wr_en & (reg_sel == REG_IE);

   // ==================================================================
   // IF and IE
   // ==================================================================
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         if_q <= '0;
         ie_q <= '0;
      end else begin
         // New requests are ORed in after the write so they are not lost
         if (if_wr) begin
            if_q <= wr_data[NUM_INT-1:0] | req_vec;
         end else begin
            if_q <= if_q | req_vec;
         end
         if (ie_wr) begin
            ie_q <= wr_data;
         end
      end
   end

   assign pending = if_q & ie_q[NUM_INT-1:0];
   assign irq     = |pending;

   // Scan from the top down so the lowest pending index wins
   always_comb begin
      irq_source = INT_VBLANK;
      for (int i = NUM_INT - 1; i >= 0; i--) begin
         if (pending[i]) begin
            irq_source = int_source_e'(i);
         end
      end
   end

   assign if_value = {{(DATA_W-NUM_INT){1'b1}}, if_q};
   assign ie_value = ie_q;

endmodule

// File: src/debug_readout.sv
`timescale 1ns/10ps

module debug_readout (
   input  logic                          clock_in,
   input  logic                          synch_reset,
   input  logic [7:0]                    switches,
   input  logic [gbc_io_pkg::DATA_W-1:0] div_value,
   input  logic [gbc_io_pkg::DATA_W-1:0] tima_value,
   input  logic [gbc_io_pkg::DATA_W-1:0] tma_value,
   input  logic [gbc_io_pkg::DATA_W-1:0] tac_value,
   input  logic [gbc_io_pkg::DATA_W-1:0] if_value,
   input  logic [gbc_io_pkg::DATA_W-1:0] ie_value,
   output logic [7:0]                    led
);
   import gbc_io_pkg::*;

   logic [HEARTBEAT_BITS-1:0] prescale;
   logic [DATA_W-1:0]         heartbeat;

   // Slow counter with its first tick after 2^21 clocks
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         prescale  <= '0;
         heartbeat <= '0;
      end else begin
         prescale <= prescale + 1'b1;
         if (prescale == '1) begin
            heartbeat <= heartbeat + 1'b1;
         end
      end
   end

   // Offset 0xFF belongs to the heartbeat, so IE shows one below it
   always_comb begin
      case (switches)
         ADDR_DIV:  led = div_value;
         ADDR_TIMA: led = tima_value;
         ADDR_TMA:  led = tma_value;
         ADDR_TAC:  led = tac_value;
         ADDR_IF:   led = if_value;
         8'hFE:     led = ie_value;
         8'hFF:     led = heartbeat;
         default:   led = '0;
      endcase
   end

endmodule

// File: src/gbc_io_top.sv
`timescale 1ns/10ps

module gbc_io_top (
   input  logic                          clock_in,
   input  logic                          synch_reset,
   input  logic [gbc_io_pkg::ADDR_W-1:0] paddr,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [gbc_io_pkg::DATA_W-1:0] pwdata,
   output logic [gbc_io_pkg::DATA_W-1:0] prdata,
   output logic                          pready,
   output logic                          pslverr,
   input  logic                          vblank_req,
   input  logic                          lcdstat_req,
   input  logic                          joypad_req,
   input  logic [7:0]                    switches,
   output logic                          irq,
   output gbc_io_pkg::int_source_e       irq_source,
   output logic [7:0]                    led
);
   import gbc_io_pkg::*;

   io_reg_e           reg_sel;
   logic              wr_en;
   logic [DATA_W-1:0] wr_data;
   logic [DATA_W-1:0] div_value;
   logic [DATA_W-1:0] tima_value;
   logic [DATA_W-1:0] tma_value;
   logic [DATA_W-1:0] tac_value;
   logic [DATA_W-1:0] if_value;
   logic [DATA_W-1:0] ie_value;
   logic              timer_req;

   // ==================================================================
   // Bus side
   // ==================================================================
   apb_io_port apb_io_port_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .div_value   (div_value),
      .tima_value  (tima_value),
      .tma_value   (tma_value),
      .tac_value   (tac_value),
      .if_value    (if_value),
      .ie_value    (ie_value),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .reg_sel     (reg_sel),
      .wr_en       (wr_en),
      .wr_data     (wr_data)
   );

   // ==================================================================
   // Timer and interrupts
   // ==================================================================
   timer_unit timer_unit_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .reg_sel     (reg_sel),
      .wr_en       (wr_en),
      .wr_data     (wr_data),
      .div_value   (div_value),
      .tima_value  (tima_value),
      .tma_value   (tma_value),
      .tac_value   (tac_value),
      .timer_req   (timer_req)
   );

   interrupt_unit interrupt_unit_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .reg_sel     (reg_sel),
      .wr_en       (wr_en),
      .wr_data     (wr_data),
      .vblank_req  (vblank_req),
      .lcdstat_req (lcdstat_req),
      .timer_req   (timer_req),
      .joypad_req  (joypad_req),
      .if_value    (if_value),
      .ie_value    (ie_value),
      .irq         (irq),
      .irq_source  (irq_source)
   );

   // LED view of the registers
   debug_readout debug_readout_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .switches    (switches),
      .div_value   (div_value),
      .tima_value  (tima_value),
      .tma_value   (tma_value),
      .tac_value   (tac_value),
      .if_value    (if_value),
      .ie_value    (ie_value),
      .led         (led)
   );

endmodule

// File: dv/gbc_io_tb.sv
`timescale 1ns/10ps

module gbc_io_tb;
   import gbc_io_pkg::*;

   localparam int          CLK_HALF      = 10;
   localparam int          RESET_CYCLES  = 5;
   localparam int          READY_TIMEOUT = 16;
   localparam int          POLL_TIMEOUT  = 64;
   localparam logic [31:0] SEED          = 32'hd872_f17a;

   logic              clock_in = 1'b0;
   logic              synch_reset;
   logic [ADDR_W-1:0] paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic              pready;
   logic              pslverr;
   logic              vblank_req;
   logic              lcdstat_req;
   logic              joypad_req;
   logic [7:0]        switches;
   logic              irq;
   int_source_e       irq_source;
   logic [7:0]        led;

   integer seed;
   int     error_count = 0;
   int     pass_count = 0;
   int     fail_count = 0;

   always #CLK_HALF clock_in = ~clock_in;

   gbc_io_top gbc_io_top_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .vblank_req  (vblank_req),
      .lcdstat_req (lcdstat_req),
      .joypad_req  (joypad_req),
      .switches    (switches),
      .irq         (irq),
      .irq_source  (irq_source),
      .led         (led)
   );

   // ==================================================================
   // Compare tasks and helpers
   // ==================================================================
   task automatic check_byte(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                             input string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: %s got 0x%02h, expected 0x%02h",
                  $time, what, actual, expected);
         error_count++;
      end
   endtask

   task automatic check_bit(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, what, actual, expected);
         error_count++;
      end
   endtask

   task automatic check_source(input int_source_e actual, input int_source_e expected,
                               input string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: %s got %s, expected %s",
                  $time, what, actual.name(), expected.name());
         error_count++;
      end
   endtask

   function automatic logic [ADDR_W-1:0] io_addr(input logic [7:0] offset);
      io_addr = {IO_PAGE, offset};
   endfunction

   function automatic logic [DATA_W-1:0] rand_byte();
      rand_byte = DATA_W'($random(seed));
   endfunction

   // Setup cycle, then access cycle sampled half way through the low phase
   task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata, output logic err);
      int waited;
      waited = 0;
      @(negedge clock_in);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clock_in);
      penable = 1'b1;
      #(CLK_HALF / 2);
      while (!pready && waited < READY_TIMEOUT) begin
         @(negedge clock_in);
         #(CLK_HALF / 2);
         waited++;
      end
      if (!pready) begin
         $display("Timeout: pready stayed low on address 0x%04h at %0t", addr, $time);
         error_count++;
      end
      rdata = prdata;
      err   = pslverr;
      @(negedge clock_in);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      logic [DATA_W-1:0] unused_data;
      logic              unused_err;
      apb_transfer(1'b1, addr, data, unused_data, unused_err);
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic err);
      apb_transfer(1'b0, addr, '0, data, err);
   endtask

   task automatic read_expect(input logic [7:0] offset, input logic [DATA_W-1:0] expected,
                              input string what);
      logic [DATA_W-1:0] data;
      logic              err;
      apb_read(io_addr(offset), data, err);
      check_byte(data, expected, what);
      check_bit(err, 1'b0, {what, " pslverr"});
   endtask

   task automatic show_led(input logic [7:0] sel, input logic [DATA_W-1:0] expected,
                           input string what);
      @(negedge clock_in);
      switches = sel;
      #(CLK_HALF / 2);
      check_byte(led, expected, what);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         pass_count++;
         $display("PASS  %s", name);
      end else begin
         fail_count++;
         $display("FAIL  %s (%0d errors)", name, error_count - errors_before);
      end
   endtask

   // ==================================================================
   // Directed tests
   // ==================================================================
   task automatic test_reset_access();
      int                errors_before;
      logic [DATA_W-1:0] value;
      logic [DATA_W-1:0] data;
      logic              err;
      errors_before = error_count;
      read_expect(ADDR_TAC, 8'hF8, "TAC after reset");
      read_expect(ADDR_IF, 8'hE0, "IF after reset");
      read_expect(ADDR_IE, 8'h00, "IE after reset");
      check_bit(irq, 1'b0, "irq after reset");
      value = rand_byte();
      apb_write(io_addr(ADDR_TMA), value);
      read_expect(ADDR_TMA, value, "TMA readback");
      value = rand_byte();
      apb_write(io_addr(ADDR_IE), value);
      read_expect(ADDR_IE, value, "IE readback");
      value = rand_byte();
      apb_write(io_addr(ADDR_IF), value);
      read_expect(ADDR_IF, {3'b111, value[4:0]}, "IF readback");
      value = rand_byte();
      apb_write(io_addr(ADDR_TAC), value);
      read_expect(ADDR_TAC, {5'b11111, value[2:0]}, "TAC readback");
      apb_write(io_addr(ADDR_TAC), 8'h00);
      apb_write(io_addr(ADDR_IF), 8'h00);
      apb_write(io_addr(ADDR_IE), 8'h00);
      apb_read(16'hFF10, data, err);
      check_byte(data, UNMAPPED_READ, "read 0xFF10 data");
      check_bit(err, 1'b1, "read 0xFF10 pslverr");
      apb_transfer(1'b1, 16'h0004, rand_byte(), data, err);
      check_bit(err, 1'b1, "write 0x0004 pslverr");
      apb_read(16'h0004, data, err);
      check_byte(data, UNMAPPED_READ, "read 0x0004 data");
      check_bit(err, 1'b1, "read 0x0004 pslverr");
      finish_test("reset and register access", errors_before);
   endtask

   task automatic test_divider();
      int errors_before;
      int idle;
      errors_before = error_count;
      idle = 300 + ($random(seed) & 127);
      apb_write(io_addr(ADDR_DIV), rand_byte());
      repeat (idle) @(negedge clock_in);
      // Two more clocks pass in the read before its access cycle is sampled
      read_expect(ADDR_DIV, DATA_W'((idle + 2) / 256), "DIV after idle cycles");
      apb_write(io_addr(ADDR_DIV), rand_byte());
      read_expect(ADDR_DIV, 8'h00, "DIV after second write");
      finish_test("divider", errors_before);
   endtask

   task automatic test_timer_overflow();
      int                errors_before;
      int                polls;
      logic [DATA_W-1:0] tma_v;
      logic [DATA_W-1:0] data;
      logic              err;
      errors_before = error_count;
      polls = 0;
      data = '0;
      tma_v = rand_byte();
      apb_write(io_addr(ADDR_TMA), tma_v);
      apb_write(io_addr(ADDR_TIMA), 8'hFE);
      apb_write(io_addr(ADDR_TAC), {5'b00000, 1'b1, TAC_16});
      while (!data[INT_TIMER] && polls < POLL_TIMEOUT) begin
         apb_read(io_addr(ADDR_IF), data, err);
         polls++;
      end
      if (!data[INT_TIMER]) begin
         $display("Timeout: timer interrupt flag was never set");
         error_count++;
      end
      apb_read(io_addr(ADDR_TIMA), data, err);
      if (data !== tma_v && data !== DATA_W'(tma_v + 1)) begin
         $display("CHECK FAILED at %0t: TIMA after overflow 0x%02h, TMA 0x%02h",
                  $time, data, tma_v);
         error_count++;
      end
      check_bit(irq, 1'b0, "irq with IE clear");
      apb_write(io_addr(ADDR_IE), 8'd1 << INT_TIMER);
      check_bit(irq, 1'b1, "irq with timer enabled");
      check_source(irq_source, INT_TIMER, "source after overflow");
      apb_write(io_addr(ADDR_TAC), 8'h00);
      apb_write(io_addr(ADDR_IF), 8'h00);
      apb_write(io_addr(ADDR_IE), 8'h00);
      finish_test("timer overflow", errors_before);
   endtask

   task automatic test_external_irq();
      int errors_before;
      errors_before = error_count;
      @(negedge clock_in);
      joypad_req  = 1'b1;
      lcdstat_req = 1'b1;
      @(negedge clock_in);
      joypad_req  = 1'b0;
      lcdstat_req = 1'b0;
      apb_write(io_addr(ADDR_IE), 8'hFF);
      read_expect(ADDR_IF, 8'hE0 | (8'd1 << INT_LCDSTAT) | (8'd1 << INT_JOYPAD),
                  "IF after requests");
      check_bit(irq, 1'b1, "irq with two pending");
      check_source(irq_source, INT_LCDSTAT, "lowest pending source");
      apb_write(io_addr(ADDR_IF), 8'd1 << INT_JOYPAD);
      check_source(irq_source, INT_JOYPAD, "source after clearing LCD STAT");
      apb_write(io_addr(ADDR_IF), 8'h00);
      check_bit(irq, 1'b0, "irq after clearing IF");
      apb_write(io_addr(ADDR_IE), 8'h00);
      finish_test("external interrupts and priority", errors_before);
   endtask

   task automatic test_debug_readout();
      int                errors_before;
      logic [DATA_W-1:0] tma_v;
      logic [DATA_W-1:0] tima_v;
      logic [DATA_W-1:0] ie_v;
      errors_before = error_count;
      tma_v  = rand_byte();
      tima_v = rand_byte();
      ie_v   = rand_byte();
      apb_write(io_addr(ADDR_TMA), tma_v);
      apb_write(io_addr(ADDR_TIMA), tima_v);
      apb_write(io_addr(ADDR_TAC), {6'b000000, TAC_64});
      apb_write(io_addr(ADDR_IF), 8'd1 << INT_SERIAL);
      apb_write(io_addr(ADDR_IE), ie_v);
      apb_write(io_addr(ADDR_DIV), 8'h00);
      show_led(ADDR_DIV, 8'h00, "led DIV");
      show_led(ADDR_TIMA, tima_v, "led TIMA");
      show_led(ADDR_TMA, tma_v, "led TMA");
      show_led(ADDR_TAC, 8'hFA, "led TAC");
      show_led(ADDR_IF, 8'hE8, "led IF");
      // IE sits one below the heartbeat offset
      show_led(8'hFE, ie_v, "led IE");
      show_led(8'h10, 8'h00, "led unmapped offset");
      show_led(8'hFF, 8'h00, "led heartbeat");
      apb_write(io_addr(ADDR_IF), 8'h00);
      apb_write(io_addr(ADDR_IE), 8'h00);
      finish_test("debug readout", errors_before);
   endtask

   // ==================================================================
   // Main sequence
   // ==================================================================
   initial begin
      seed        = SEED;
      synch_reset = 1'b1;
      paddr       = '0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      pwdata      = '0;
      vblank_req  = 1'b0;
      lcdstat_req = 1'b0;
      joypad_req  = 1'b0;
      switches    = '0;
      repeat (RESET_CYCLES) @(posedge clock_in);
      @(negedge clock_in);
      synch_reset = 1'b0;

      test_reset_access();
      test_divider();
      test_timer_overflow();
      test_external_irq();
      test_debug_readout();

      $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
               pass_count, fail_count, error_count);
      if (fail_count == 0 && error_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: gbc_io.f
src/gbc_io_pkg.sv
src/apb_io_port.sv
src/timer_unit.sv
src/interrupt_unit.sv
src/debug_readout.sv
src/gbc_io_top.sv
dv/gbc_io_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = gbc_io_tb
FILELIST  = gbc_io.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
